/* compile.f */
+incdir+design
design/odd_pipe_pkg.sv
design/fw_if.sv
design/issue_control.sv
design/drain_timer.sv
design/permute_unit.sv
design/branch_unit.sv
design/result_pipe.sv
design/odd_pipe_top.sv
sim/odd_pipe_checker.sv
sim/odd_pipe_tb.sv

/* design/branch_unit.sv */
`default_nettype none

`include "odd_pipe_consts.svh"

module branch_unit
(
    input  wire logic                       clock,
    input  wire logic                       arst_n,
    input  wire logic                       issue_fire,
    input  odd_pipe_pkg::odd_op_e           op_code,
    input  odd_pipe_pkg::quad_t             rt_in,
    input  wire logic [0:`REG_ADDR_WIDTH-1] rt_address,
    input  wire logic [0:15]                i16,
    input  wire logic [0:`WORD_WIDTH-1]     pc_in,
    output logic                            pc_valid,
    output logic [0:`WORD_WIDTH-1]          pc_out,
    fw_if.unit                              fw
);

    logic [0:`WORD_WIDTH-1] offset;
    logic [0:`WORD_WIDTH-1] seq;
    logic [0:`WORD_WIDTH-1] rel;
    logic [0:`WORD_WIDTH-1] abs_tgt;
    logic [0:`WORD_WIDTH-1] rel_taken;
    logic [0:`WORD_WIDTH-1] pc_next;
    logic pc_v;
    logic link;

    // word offset, sign extended
    assign offset = {{14{i16[0]}}, i16, 2'b00};
    assign seq = (pc_in + `WORD_WIDTH'(`PC_STEP)) & `LSLR;
    assign rel = (pc_in + offset) & `LSLR;
    assign abs_tgt = offset & `LSLR;
    assign rel_taken = rel & ~`WORD_WIDTH'(3);

    always_comb
    begin
        pc_v = 1'b1;
        pc_next = seq;
        link = 1'b0;
        case (op_code)
            odd_pipe_pkg::op_br:    pc_next = rel;
            odd_pipe_pkg::op_bra:   pc_next = abs_tgt;
            odd_pipe_pkg::op_brsl:
            begin
                pc_next = rel;
                link = 1'b1;
            end
            odd_pipe_pkg::op_brasl:
            begin
                pc_next = abs_tgt;
                link = 1'b1;
            end
            odd_pipe_pkg::op_brnz:  pc_next = (rt_in[0:31] != '0) ? rel_taken : seq;
            odd_pipe_pkg::op_brz:   pc_next = (rt_in[0:31] == '0) ? rel_taken : seq;
            odd_pipe_pkg::op_brhnz: pc_next = (rt_in[16:31] != '0) ? rel_taken : seq;
            odd_pipe_pkg::op_brhz:  pc_next = (rt_in[16:31] == '0) ? rel_taken : seq;
            // stop reports the next sequential address
            odd_pipe_pkg::op_stop:  pc_next = seq;
            default:                pc_v = 1'b0;
        endcase
    end

    assign fw.wrt_en = fw.valid;

    always_ff @(posedge clock or negedge arst_n)
    begin
        if (!arst_n)
        begin
            pc_valid <= 1'b0;
            fw.valid <= 1'b0;
        end
        else
        begin
            pc_valid <= issue_fire && pc_v;
            fw.valid <= issue_fire && link;
        end
    end

    always_ff @(posedge clock)
    begin
        if (issue_fire)
        begin
            pc_out <= pc_next;
            fw.rt_value <= {seq, {(`QW_WIDTH - `WORD_WIDTH){1'b0}}};
            fw.rt_address <= rt_address;
        end
    end

endmodule

`default_nettype wire

/* design/drain_timer.sv */
`default_nettype none

`include "odd_pipe_consts.svh"

module drain_timer
(
    input  wire logic clock,
    input  wire logic arst_n,
    input  wire logic start,
    output logic      done
);

    localparam int CNT_W = $clog2(`WB_LATENCY);

    logic [CNT_W-1:0] count;

    // done marks the cycle in which the count steps down to zero
    assign done = (count == CNT_W'(1));

    always_ff @(posedge clock or negedge arst_n)
    begin
        if (!arst_n)
            count <= '0;
        else if (start)
            count <= CNT_W'(`WB_LATENCY - 1);
        else if (count != '0)
            count <= count - CNT_W'(1);
    end

endmodule

`default_nettype wire

/* design/fw_if.sv */
`default_nettype none

`include "odd_pipe_consts.svh"

// one unit's result on its way to writeback
interface fw_if;

    logic valid;
    logic wrt_en;
    logic [0:`REG_ADDR_WIDTH-1] rt_address;
    odd_pipe_pkg::quad_t rt_value;

    modport unit (output valid, output wrt_en, output rt_address, output rt_value);

    modport pipe (input valid, input wrt_en, input rt_address, input rt_value);

endinterface

`default_nettype wire

/* design/issue_control.sv */
`default_nettype none

module issue_control
(
    input  wire logic               clock,
    input  wire logic               arst_n,
    input  wire logic               issue_valid,
    input  odd_pipe_pkg::odd_op_e   op_code,
    input  wire logic               resume,
    input  wire logic               done,
    output logic                    issue_ready,
    output logic                    issue_fire,
    output logic                    start,
    output logic                    halted
);

    odd_pipe_pkg::issue_state_e state;
    odd_pipe_pkg::issue_state_e state_next;
    logic ready_q;

    assign issue_ready = ready_q;
    assign issue_fire = issue_valid && ready_q;
    assign start = issue_fire && (op_code == odd_pipe_pkg::op_stop);
    assign halted = (state == odd_pipe_pkg::st_halted);

    always_comb
    begin
        state_next = state;
        case (state)
            odd_pipe_pkg::st_run:
                if (start)
                    state_next = odd_pipe_pkg::st_drain;
            odd_pipe_pkg::st_drain:
                if (done)
                    state_next = odd_pipe_pkg::st_halted;
            odd_pipe_pkg::st_halted:
                if (resume)
                    state_next = odd_pipe_pkg::st_run;
            default:
                state_next = odd_pipe_pkg::st_run;
        endcase
    end

    // ready is registered so it drops on the edge that takes the stop
    always_ff @(posedge clock or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state <= odd_pipe_pkg::st_run;
            ready_q <= 1'b0;
        end
        else
        begin
            state <= state_next;
            ready_q <= (state_next == odd_pipe_pkg::st_run);
        end
    end

    a_halt_needs_resume: assert property (
        @(posedge clock) disable iff (!arst_n)
        (state == odd_pipe_pkg::st_halted) && !resume |=> (state == odd_pipe_pkg::st_halted)
    );

endmodule

`default_nettype wire

/* design/odd_pipe_consts.svh */
`ifndef ODD_PIPE_CONSTS_SVH
`define ODD_PIPE_CONSTS_SVH

// operand and register file geometry
`define QW_WIDTH 128
`define WORD_WIDTH 32
`define REG_ADDR_WIDTH 7

// issue to writeback, in cycles
`define WB_LATENCY 4

// local store address limit
`define LSLR 32'h0003_FFFF

`define PC_STEP 4

`endif

/* design/odd_pipe_pkg.sv */
`default_nettype none

`include "odd_pipe_consts.svh"

package odd_pipe_pkg;

    typedef enum logic [4:0]
    {
        op_shlqbi,
        op_shlqbii,
        op_shlqby,
        op_shlqbyi,
        op_shlqbybi,
        op_rotqby,
        op_rotqbyi,
        op_rotqbybi,
        op_rotqbi,
        op_rotqbii,
        op_gb,
        op_gbh,
        op_gb_w,
        op_br,
        op_bra,
        op_brsl,
        op_brasl,
        op_brnz,
        op_brz,
        op_brhnz,
        op_brhz,
        op_stop,
        op_nop
    } odd_op_e;

    typedef enum logic [1:0]
    {
        st_run,
        st_drain,
        st_halted
    } issue_state_e;

    // bit 0 is the most significant bit
    typedef logic [0:`QW_WIDTH-1] quad_t;

endpackage

`default_nettype wire

/* design/odd_pipe_top.sv */
`default_nettype none

`include "odd_pipe_consts.svh"

module odd_pipe_top
(
    input  wire logic                       clock,
    input  wire logic                       arst_n,
    input  wire logic                       issue_valid,
    input  odd_pipe_pkg::odd_op_e           op_code,
    input  odd_pipe_pkg::quad_t             ra,
    input  odd_pipe_pkg::quad_t             rb,
    input  odd_pipe_pkg::quad_t             rt_in,
    input  wire logic [0:`REG_ADDR_WIDTH-1] rt_address,
    input  wire logic [0:6]                 i7,
    input  wire logic [0:15]                i16,
    input  wire logic [0:`WORD_WIDTH-1]     pc_in,
    input  wire logic                       resume,
    output logic                            issue_ready,
    output logic                            pc_valid,
    output logic [0:`WORD_WIDTH-1]          pc_out,
    output logic                            wb_valid,
    output logic [0:`REG_ADDR_WIDTH-1]      wb_address,
    output odd_pipe_pkg::quad_t             wb_value,
    output logic                            halted
);

    logic issue_fire;
    logic start;
    logic done;

    fw_if perm_fw ();
    fw_if br_fw ();

    issue_control u_issue_control
    (
        .clock       (clock),
        .arst_n      (arst_n),
        .issue_valid (issue_valid),
        .op_code     (op_code),
        .resume      (resume),
        .done        (done),
        .issue_ready (issue_ready),
        .issue_fire  (issue_fire),
        .start       (start),
        .halted      (halted)
    );

    drain_timer u_drain_timer
    (
        .clock  (clock),
        .arst_n (arst_n),
        .start  (start),
        .done   (done)
    );

    permute_unit u_permute_unit
    (
        .clock      (clock),
        .arst_n     (arst_n),
        .issue_fire (issue_fire),
        .op_code    (op_code),
        .ra         (ra),
        .rb         (rb),
        .i7         (i7),
        .rt_address (rt_address),
        .fw         (perm_fw.unit)
    );

    branch_unit u_branch_unit
    (
        .clock      (clock),
        .arst_n     (arst_n),
        .issue_fire (issue_fire),
        .op_code    (op_code),
        .rt_in      (rt_in),
        .rt_address (rt_address),
        .i16        (i16),
        .pc_in      (pc_in),
        .pc_valid   (pc_valid),
        .pc_out     (pc_out),
        .fw         (br_fw.unit)
    );

    result_pipe u_result_pipe
    (
        .clock      (clock),
        .arst_n     (arst_n),
        .perm_fw    (perm_fw.pipe),
        .br_fw      (br_fw.pipe),
        .wb_valid   (wb_valid),
        .wb_address (wb_address),
        .wb_value   (wb_value)
    );

endmodule

`default_nettype wire

/* design/permute_unit.sv */
`default_nettype none

`include "odd_pipe_consts.svh"

module permute_unit
(
    input  wire logic                       clock,
    input  wire logic                       arst_n,
    input  wire logic                       issue_fire,
    input  odd_pipe_pkg::odd_op_e           op_code,
    input  odd_pipe_pkg::quad_t             ra,
    input  odd_pipe_pkg::quad_t             rb,
    input  wire logic [0:6]                 i7,
    input  wire logic [0:`REG_ADDR_WIDTH-1] rt_address,
    fw_if.unit                              fw
);

    // shift amount in bits, byte forms already scaled by 8
    logic [7:0] amt;
    logic rot;
    logic is_perm;
    logic is_gather;
    odd_pipe_pkg::quad_t gathered;
    odd_pipe_pkg::quad_t shifted;
    odd_pipe_pkg::quad_t rotated;
    odd_pipe_pkg::quad_t result;

    // lsb of each element, element 0 lands at the top of the field
    function automatic odd_pipe_pkg::quad_t gather(input odd_pipe_pkg::quad_t v, input int ew);
        odd_pipe_pkg::quad_t r;
        int n;
        r = '0;
        n = `QW_WIDTH / ew;
        for (int j = 0; j < `QW_WIDTH / 8; j++)
        begin
            if (j < n)
                r[`WORD_WIDTH - n + j] = v[j * ew + ew - 1];
        end
        return r;
    endfunction

    always_comb
    begin
        amt = '0;
        rot = 1'b0;
        is_perm = 1'b1;
        is_gather = 1'b0;
        gathered = '0;
        case (op_code)
            odd_pipe_pkg::op_shlqbi:   amt = {5'b0, rb[29:31]};
            odd_pipe_pkg::op_shlqbii:  amt = {5'b0, i7[4:6]};
            odd_pipe_pkg::op_shlqby:   amt = {rb[27:31], 3'b000};
            odd_pipe_pkg::op_shlqbyi:  amt = {i7[2:6], 3'b000};
            odd_pipe_pkg::op_shlqbybi: amt = {rb[24:28], 3'b000};
            odd_pipe_pkg::op_rotqby:
            begin
                amt = {1'b0, rb[28:31], 3'b000};
                rot = 1'b1;
            end
            odd_pipe_pkg::op_rotqbyi:
            begin
                amt = {1'b0, i7[3:6], 3'b000};
                rot = 1'b1;
            end
            odd_pipe_pkg::op_rotqbybi:
            begin
                // only the count modulo 16 matters for a rotate
                amt = {1'b0, rb[25:28], 3'b000};
                rot = 1'b1;
            end
            odd_pipe_pkg::op_rotqbi:
            begin
                amt = {5'b0, rb[29:31]};
                rot = 1'b1;
            end
            odd_pipe_pkg::op_rotqbii:
            begin
                amt = {5'b0, i7[4:6]};
                rot = 1'b1;
            end
            odd_pipe_pkg::op_gb:
            begin
                gathered = gather(ra, 8);
                is_gather = 1'b1;
            end
            odd_pipe_pkg::op_gbh:
            begin
                gathered = gather(ra, 16);
                is_gather = 1'b1;
            end
            odd_pipe_pkg::op_gb_w:
            begin
                gathered = gather(ra, 32);
                is_gather = 1'b1;
            end
            default:   is_perm = 1'b0;
        endcase
    end

    // left is toward bit 0, so a plain left shift; 16 bytes or more clears it
    assign shifted = ra << amt;
    assign rotated = shifted | (ra >> (`QW_WIDTH - amt));
    assign result = is_gather ? gathered : (rot ? rotated : shifted);

    assign fw.wrt_en = fw.valid;

    always_ff @(posedge clock or negedge arst_n)
    begin
        if (!arst_n)
            fw.valid <= 1'b0;
        else
            fw.valid <= issue_fire && is_perm;
    end

    always_ff @(posedge clock)
    begin
        if (issue_fire)
        begin
            fw.rt_value <= result;
            fw.rt_address <= rt_address;
        end
    end

    a_perm_only: assert property (
        @(posedge clock) disable iff (!arst_n)
        issue_fire && !(op_code inside {odd_pipe_pkg::op_shlqbi, odd_pipe_pkg::op_shlqbii,
                                        odd_pipe_pkg::op_shlqby, odd_pipe_pkg::op_shlqbyi,
                                        odd_pipe_pkg::op_shlqbybi, odd_pipe_pkg::op_rotqby,
                                        odd_pipe_pkg::op_rotqbyi, odd_pipe_pkg::op_rotqbybi,
                                        odd_pipe_pkg::op_rotqbi, odd_pipe_pkg::op_rotqbii,
                                        odd_pipe_pkg::op_gb, odd_pipe_pkg::op_gbh,
                                        odd_pipe_pkg::op_gb_w})
        |=> !fw.valid
    );

endmodule

`default_nettype wire

/* design/result_pipe.sv */
`default_nettype none

`include "odd_pipe_consts.svh"

module result_pipe
(
    input  wire logic                  clock,
    input  wire logic                  arst_n,
    fw_if.pipe                         perm_fw,
    fw_if.pipe                         br_fw,
    output logic                       wb_valid,
    output logic [0:`REG_ADDR_WIDTH-1] wb_address,
    output odd_pipe_pkg::quad_t        wb_value
);

    // the unit register already counts as the first cycle
    localparam int DEPTH = `WB_LATENCY - 1;

    logic in_v;
    logic [0:`REG_ADDR_WIDTH-1] in_addr;
    odd_pipe_pkg::quad_t in_val;
    logic [DEPTH-1:0] v_q;
    logic [0:`REG_ADDR_WIDTH-1] addr_q [DEPTH];
    odd_pipe_pkg::quad_t val_q [DEPTH];

    assign in_v = (perm_fw.valid && perm_fw.wrt_en) || (br_fw.valid && br_fw.wrt_en);
    assign in_addr = perm_fw.valid ? perm_fw.rt_address : br_fw.rt_address;
    assign in_val = perm_fw.valid ? perm_fw.rt_value : br_fw.rt_value;

    always_ff @(posedge clock or negedge arst_n)
    begin
        if (!arst_n)
            v_q <= '0;
        else
            v_q <= {v_q[DEPTH-2:0], in_v};
    end

    always_ff @(posedge clock)
    begin
        addr_q[0] <= in_addr;
        val_q[0] <= in_val;
        for (int i = 1; i < DEPTH; i++)
        begin
            addr_q[i] <= addr_q[i-1];
            val_q[i] <= val_q[i-1];
        end
    end

    assign wb_valid = v_q[DEPTH-1];
    assign wb_address = addr_q[DEPTH-1];
    assign wb_value = val_q[DEPTH-1];

    // single issue means the units never finish in the same cycle
    a_one_source: assert property (
        @(posedge clock) disable iff (!arst_n)
        !(perm_fw.valid && br_fw.valid)
    );

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module odd_pipe_tb
out=$(./obj_dir/Vodd_pipe_tb) || true
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -qx "All checks passed"
then
    exit 0
fi
exit 1

/* sim/odd_pipe_checker.sv */
`default_nettype none

`include "odd_pipe_consts.svh"

module odd_pipe_checker
(
    input  wire logic                       clock,
    input  wire logic                       arst_n,
    input  wire logic                       issue_valid,
    input  wire logic                       issue_ready,
    input  odd_pipe_pkg::odd_op_e           op_code,
    input  odd_pipe_pkg::quad_t             ra,
    input  odd_pipe_pkg::quad_t             rb,
    input  odd_pipe_pkg::quad_t             rt_in,
    input  wire logic [0:`REG_ADDR_WIDTH-1] rt_address,
    input  wire logic [0:6]                 i7,
    input  wire logic [0:15]                i16,
    input  wire logic [0:`WORD_WIDTH-1]     pc_in,
    input  wire logic                       resume,
    input  wire logic                       pc_valid,
    input  wire logic [0:`WORD_WIDTH-1]     pc_out,
    input  wire logic                       wb_valid,
    input  wire logic [0:`REG_ADDR_WIDTH-1] wb_address,
    input  odd_pipe_pkg::quad_t             wb_value,
    input  wire logic                       halted,
    output int                              wb_errors,
    output int                              pc_errors,
    output int                              ctrl_errors,
    output int                              pending
);

    int cycle;
    int stop_cycle;
    logic stop_wait;
    logic resume_seen;
    logic halted_d;
    logic exp_wb_en;
    logic exp_pc_en;
    odd_pipe_pkg::quad_t exp_wb;
    logic [31:0] exp_pc;

    // expected results, oldest first, tagged with the cycle they are due
    int wb_due [$];
    logic [0:`REG_ADDR_WIDTH-1] wb_addr_q [$];
    odd_pipe_pkg::quad_t wb_val_q [$];
    int pc_due [$];
    logic [31:0] pc_val_q [$];

    function automatic void predict
    (
        input  odd_pipe_pkg::odd_op_e op,
        input  odd_pipe_pkg::quad_t   a,
        input  odd_pipe_pkg::quad_t   b,
        input  odd_pipe_pkg::quad_t   t,
        input  logic [0:6]            imm7,
        input  logic [0:15]           imm16,
        input  logic [31:0]           pc,
        output logic                  has_wb,
        output odd_pipe_pkg::quad_t   wb,
        output logic                  has_pc,
        output logic [31:0]           npc
    );
        logic [31:0] pw;
        logic [31:0] off;
        logic [31:0] seq;
        logic [31:0] rel;
        logic [31:0] field;
        int cnt;
        int esize;
        logic perm;
        logic taken;
        pw = b[0:31];
        off = {{16{imm16[0]}}, imm16} << 2;
        seq = (pc + 32'(`PC_STEP)) & `LSLR;
        rel = (pc + off) & `LSLR;
        has_wb = 1'b0;
        wb = '0;
        npc = '0;
        cnt = 0;
        esize = 0;
        perm = 1'b1;
        taken = 1'b0;
        // cnt is the amount in bits
        case (op)
            odd_pipe_pkg::op_shlqbi:   cnt = pw % 8;
            odd_pipe_pkg::op_shlqbii:  cnt = int'(imm7) % 8;
            odd_pipe_pkg::op_shlqby:   cnt = 8 * (pw % 32);
            odd_pipe_pkg::op_shlqbyi:  cnt = 8 * (int'(imm7) % 32);
            odd_pipe_pkg::op_shlqbybi: cnt = 8 * ((pw >> 3) % 32);
            odd_pipe_pkg::op_rotqbi:   cnt = pw % 8;
            odd_pipe_pkg::op_rotqbii:  cnt = int'(imm7) % 8;
            odd_pipe_pkg::op_rotqby:   cnt = 8 * (pw % 16);
            odd_pipe_pkg::op_rotqbyi:  cnt = 8 * (int'(imm7) % 16);
            odd_pipe_pkg::op_rotqbybi: cnt = 8 * ((pw >> 3) % 16);
            odd_pipe_pkg::op_gb:       esize = 8;
            odd_pipe_pkg::op_gbh:      esize = 16;
            odd_pipe_pkg::op_gb_w:     esize = 32;
            default:                   perm = 1'b0;
        endcase
        if (perm && esize != 0)
        begin
            field = '0;
            for (int e = 0; e < `QW_WIDTH / esize; e++)
                field = {field[30:0], a[e * esize + esize - 1]};
            wb = {field, {(`QW_WIDTH - `WORD_WIDTH){1'b0}}};
        end
        else if (perm)
        begin
            // result bit i takes source bit i + cnt
            for (int i = 0; i < `QW_WIDTH; i++)
            begin
                if (op inside {odd_pipe_pkg::op_rotqbi, odd_pipe_pkg::op_rotqbii,
                               odd_pipe_pkg::op_rotqby, odd_pipe_pkg::op_rotqbyi,
                               odd_pipe_pkg::op_rotqbybi})
                    wb[i] = a[(i + cnt) % `QW_WIDTH];
                else
                    wb[i] = (i + cnt < `QW_WIDTH) ? a[i + cnt] : 1'b0;
            end
        end
        has_wb = perm;
        case (op)
            odd_pipe_pkg::op_br, odd_pipe_pkg::op_brsl:   npc = rel;
            odd_pipe_pkg::op_bra, odd_pipe_pkg::op_brasl: npc = off & `LSLR;
            odd_pipe_pkg::op_brnz:  taken = (t[0:31] != 0);
            odd_pipe_pkg::op_brz:   taken = (t[0:31] == 0);
            odd_pipe_pkg::op_brhnz: taken = (t[16:31] != 0);
            odd_pipe_pkg::op_brhz:  taken = (t[16:31] == 0);
            odd_pipe_pkg::op_stop:  npc = seq;
            default: ;
        endcase
        if (op inside {odd_pipe_pkg::op_brnz, odd_pipe_pkg::op_brz,
                       odd_pipe_pkg::op_brhnz, odd_pipe_pkg::op_brhz})
            npc = taken ? (rel & ~32'd3) : seq;
        has_pc = !perm && (op != odd_pipe_pkg::op_nop);
        if (op inside {odd_pipe_pkg::op_brsl, odd_pipe_pkg::op_brasl})
        begin
            has_wb = 1'b1;
            wb = {seq, {(`QW_WIDTH - `WORD_WIDTH){1'b0}}};
        end
    endfunction

    task automatic compare_writeback();
        if (wb_valid)
        begin
            if (wb_due.size() == 0 || wb_due[0] != cycle)
            begin
                $display("unexpected writeback to r%0d at %0t", wb_address, $time);
                wb_errors++;
            end
            else
            begin
                if (wb_address !== wb_addr_q[0] || wb_value !== wb_val_q[0])
                begin
                    $display("error at %0t: writeback r%0d = %h, expected r%0d = %h",
                             $time, wb_address, wb_value, wb_addr_q[0], wb_val_q[0]);
                    wb_errors++;
                end
                void'(wb_due.pop_front());
                void'(wb_addr_q.pop_front());
                void'(wb_val_q.pop_front());
            end
        end
        else if (wb_due.size() != 0 && wb_due[0] == cycle)
        begin
            $display("writeback to r%0d did not appear at %0t", wb_addr_q[0], $time);
            wb_errors++;
            void'(wb_due.pop_front());
            void'(wb_addr_q.pop_front());
            void'(wb_val_q.pop_front());
        end
    endtask

    task automatic compare_pc();
        if (pc_valid)
        begin
            if (pc_due.size() == 0 || pc_due[0] != cycle)
            begin
                $display("unexpected pc output %h at %0t", pc_out, $time);
                pc_errors++;
            end
            else
            begin
                if (pc_out !== pc_val_q[0])
                begin
                    $display("error at %0t: pc_out = %h, expected %h", $time, pc_out, pc_val_q[0]);
                    pc_errors++;
                end
                void'(pc_due.pop_front());
                void'(pc_val_q.pop_front());
            end
        end
        else if (pc_due.size() != 0 && pc_due[0] == cycle)
        begin
            $display("pc output %h did not appear at %0t", pc_val_q[0], $time);
            pc_errors++;
            void'(pc_due.pop_front());
            void'(pc_val_q.pop_front());
        end
    endtask

    // drain, halt and resume sequence after a stop
    task automatic watch_halt();
        if (resume_seen && (halted || !issue_ready))
        begin
            $display("the pipe did not restart after resume at %0t", $time);
            ctrl_errors++;
        end
        resume_seen = 1'b0;
        if (halted && !halted_d && !stop_wait)
        begin
            $display("halted rose without a stop at %0t", $time);
            ctrl_errors++;
        end
        else if (halted && !halted_d && cycle != stop_cycle + `WB_LATENCY)
        begin
            $display("error at %0t: halted rose %0d cycles after the stop, expected %0d",
                     $time, cycle - stop_cycle, `WB_LATENCY);
            ctrl_errors++;
        end
        if (stop_wait && cycle > stop_cycle && issue_ready)
        begin
            $display("issue_ready was high before resume at %0t", $time);
            ctrl_errors++;
        end
        if (stop_wait && halted && resume)
        begin
            stop_wait = 1'b0;
            resume_seen = 1'b1;
        end
        halted_d = halted;
    endtask

    task automatic record_issue();
        if (issue_valid && !issue_ready)
        begin
            $display("issue_valid was raised while issue_ready was low at %0t", $time);
            ctrl_errors++;
        end
        if (issue_valid && issue_ready)
        begin
            predict(op_code, ra, rb, rt_in, i7, i16, pc_in, exp_wb_en, exp_wb, exp_pc_en,
                    exp_pc);
            if (exp_wb_en)
            begin
                wb_due.push_back(cycle + `WB_LATENCY);
                wb_addr_q.push_back(rt_address);
                wb_val_q.push_back(exp_wb);
            end
            if (exp_pc_en)
            begin
                pc_due.push_back(cycle + 1);
                pc_val_q.push_back(exp_pc);
            end
            if (op_code == odd_pipe_pkg::op_stop)
            begin
                stop_wait = 1'b1;
                stop_cycle = cycle;
            end
        end
    endtask

    // mid-cycle sampling, the testbench drives on the rising edge
    always @(negedge clock)
    begin
        if (!arst_n)
        begin
            cycle = 0;
            stop_wait = 1'b0;
            resume_seen = 1'b0;
            halted_d = 1'b0;
            wb_due.delete();
            wb_addr_q.delete();
            wb_val_q.delete();
            pc_due.delete();
            pc_val_q.delete();
        end
        else
        begin
            cycle++;
            compare_writeback();
            compare_pc();
            watch_halt();
            record_issue();
        end
        pending = wb_due.size() + pc_due.size();
    end

endmodule

`default_nettype wire

/* sim/odd_pipe_tb.sv */
`default_nettype none

`include "odd_pipe_consts.svh"

module odd_pipe_tb;

    localparam int PERIOD = 20;
    localparam int N_SHIFT = 300;
    localparam int N_GATHER = 30;
    localparam int N_BRANCH = 80;
    localparam int N_MIX = 60;
    localparam int N_STOP = 6;
    localparam int N_ISSUE = N_SHIFT + N_GATHER + N_BRANCH + N_MIX + N_STOP;

    logic clock;
    logic arst_n;
    logic issue_valid;
    odd_pipe_pkg::odd_op_e op_code;
    odd_pipe_pkg::quad_t ra;
    odd_pipe_pkg::quad_t rb;
    odd_pipe_pkg::quad_t rt_in;
    logic [0:`REG_ADDR_WIDTH-1] rt_address;
    logic [0:6] i7;
    logic [0:15] i16;
    logic [0:`WORD_WIDTH-1] pc_in;
    logic resume;
    logic issue_ready;
    logic pc_valid;
    logic [0:`WORD_WIDTH-1] pc_out;
    logic wb_valid;
    logic [0:`REG_ADDR_WIDTH-1] wb_address;
    odd_pipe_pkg::quad_t wb_value;
    logic halted;
    int wb_errors;
    int pc_errors;
    int ctrl_errors;
    int pending;
    integer seed;

    odd_pipe_top uut
    (
        .clock       (clock),
        .arst_n      (arst_n),
        .issue_valid (issue_valid),
        .op_code     (op_code),
        .ra          (ra),
        .rb          (rb),
        .rt_in       (rt_in),
        .rt_address  (rt_address),
        .i7          (i7),
        .i16         (i16),
        .pc_in       (pc_in),
        .resume      (resume),
        .issue_ready (issue_ready),
        .pc_valid    (pc_valid),
        .pc_out      (pc_out),
        .wb_valid    (wb_valid),
        .wb_address  (wb_address),
        .wb_value    (wb_value),
        .halted      (halted)
    );

    odd_pipe_checker chk
    (
        .clock       (clock),
        .arst_n      (arst_n),
        .issue_valid (issue_valid),
        .issue_ready (issue_ready),
        .op_code     (op_code),
        .ra          (ra),
        .rb          (rb),
        .rt_in       (rt_in),
        .rt_address  (rt_address),
        .i7          (i7),
        .i16         (i16),
        .pc_in       (pc_in),
        .resume      (resume),
        .pc_valid    (pc_valid),
        .pc_out      (pc_out),
        .wb_valid    (wb_valid),
        .wb_address  (wb_address),
        .wb_value    (wb_value),
        .halted      (halted),
        .wb_errors   (wb_errors),
        .pc_errors   (pc_errors),
        .ctrl_errors (ctrl_errors),
        .pending     (pending)
    );

    always #(PERIOD / 2) clock = ~clock;

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic odd_pipe_pkg::quad_t rand_quad();
        return {$random(seed), $random(seed), $random(seed), $random(seed)};
    endfunction

    // zero words and halfwords make both branch outcomes likely
    function automatic odd_pipe_pkg::quad_t cond_operand();
        odd_pipe_pkg::quad_t v;
        v = rand_quad();
        case (rand_below(4))
            0:       v[0:31] = '0;
            1:       v[16:31] = '0;
            default: ;
        endcase
        return v;
    endfunction

    function automatic odd_pipe_pkg::odd_op_e pick(input int lo, input int hi);
        return odd_pipe_pkg::odd_op_e'(5'(lo + rand_below(hi - lo + 1)));
    endfunction

    task automatic send(input odd_pipe_pkg::odd_op_e op);
        @(posedge clock);
        issue_valid <= 1'b1;
        op_code <= op;
        ra <= rand_quad();
        rb <= rand_quad();
        rt_in <= cond_operand();
        rt_address <= 7'(rand_below(128));
        i7 <= 7'(rand_below(128));
        i16 <= 16'(rand_below(65536));
        pc_in <= $random(seed);
    endtask

    task automatic idle();
        @(posedge clock);
        issue_valid <= 1'b0;
        op_code <= odd_pipe_pkg::op_nop;
    endtask

    task automatic wait_ready();
        @(negedge clock);
        while (!issue_ready)
            @(negedge clock);
    endtask

    initial
    begin
        seed = 32'h8e0a_0658;
        clock = 1'b0;
        arst_n = 1'b0;
        issue_valid = 1'b0;
        op_code = odd_pipe_pkg::op_nop;
        ra = '0;
        rb = '0;
        rt_in = '0;
        rt_address = '0;
        i7 = '0;
        i16 = '0;
        pc_in = '0;
        resume = 1'b0;
        repeat (3)
            @(posedge clock);
        arst_n <= 1'b1;
        wait_ready();

        for (int n = 0; n < N_SHIFT; n++)
            send(pick(odd_pipe_pkg::op_shlqbi, odd_pipe_pkg::op_rotqbii));
        for (int n = 0; n < N_GATHER; n++)
            send(pick(odd_pipe_pkg::op_gb, odd_pipe_pkg::op_gb_w));
        for (int n = 0; n < N_BRANCH; n++)
            send(pick(odd_pipe_pkg::op_br, odd_pipe_pkg::op_brhz));
        for (int n = 0; n < N_MIX; n++)
        begin
            if (rand_below(8) == 0)
                send(odd_pipe_pkg::op_nop);
            else
                send(pick(odd_pipe_pkg::op_shlqbi, odd_pipe_pkg::op_brhz));
        end

        // older results must still drain after the stop
        send(odd_pipe_pkg::op_rotqby);
        send(odd_pipe_pkg::op_brasl);
        send(odd_pipe_pkg::op_stop);
        idle();
        @(negedge clock);
        while (!halted)
            @(negedge clock);
        @(posedge clock);
        resume <= 1'b1;
        @(posedge clock);
        resume <= 1'b0;
        wait_ready();
        repeat (3)
            send(pick(odd_pipe_pkg::op_shlqbi, odd_pipe_pkg::op_gb_w));
        idle();

        while (pending != 0)
            @(posedge clock);
        $display("errors: writeback %0d, pc %0d, control %0d", wb_errors, pc_errors,
                 ctrl_errors);
        if (wb_errors + pc_errors + ctrl_errors == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

    initial
    begin
        #((N_ISSUE + 20) * PERIOD);
        $display("timeout: the run did not finish within %0d cycles", N_ISSUE + 20);
        $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire
